// ==== list.f ====
rx_pkg.sv
rx_sample_if.sv
rx_settings.sv
vita_rx_control.sv
rx_sample_fifo.sv
vita_rx_framer.sv
add_routing_header.sv
vita_rx_chain.sv
vita_rx_chain_assertions.sv
tb_vita_rx_chain.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rx chain testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_vita_rx_chain \
   -o sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// ==== tb_vita_rx_chain.sv ====
/*
 * testbench for the vita rx chain
 * drives timed stream commands and checks the routed packets against logged samples
 */
`timescale 1ns/1ps

module tb_vita_rx_chain;
   // the longest test is the stalled burst with its drain and runs well under this limit
   localparam int TIMEOUT_CYCLES = 20000;

   logic                      clk_i = 1'b0;
   logic                      rst_i = 1'b1;
   logic                      set_stb_i = 1'b0;
   logic [7:0]                set_addr_i = '0;
   logic [31:0]               set_data_i = '0;
   logic [63:0]               vita_time_i = '0;
   logic [31:0]               sample_i = 32'h1000;
   logic                      strobe_i = 1'b0;
   logic                      rx_dst_rdy_i = 1'b1;
   logic [rx_pkg::LINE_W-1:0] rx_data_o;
   logic                      rx_src_rdy_o, overrun_o, run_o;

   logic [rx_pkg::LINE_W-1:0] lines [$];
   logic [31:0]               payload_q [$];
   logic [63:0]               sample_time [logic [31:0]];
   logic [rx_pkg::LINE_W-1:0] thi_line, tlo_line;
   logic [3:0]                pkt_count = 4'd0;
   logic [31:0]               next_sample;
   logic                      have_next = 1'b0;
   logic                      overrun_seen = 1'b0;
   int                        rdy_mode = 0;
   int                        cycles = 0;

   vita_rx_chain dut (.*);

   always #5 clk_i = ~clk_i;

   // free-running time, a strobe every second cycle and back-pressure
   always @(posedge clk_i) begin
      vita_time_i <= vita_time_i + 64'd1;
      strobe_i    <= !strobe_i;
      if (strobe_i) begin
         sample_i <= sample_i + 32'd1;
         sample_time[sample_i] = vita_time_i;
      end
      case (rdy_mode)
         0: rx_dst_rdy_i <= 1'b1;
         1: rx_dst_rdy_i <= 1'b0;
         default: rx_dst_rdy_i <= ($urandom % 4) != 0;
      endcase
   end

   always @(posedge clk_i) begin
      if (rx_src_rdy_o && rx_dst_rdy_i) begin
         lines.push_back(rx_data_o);
      end
      if (overrun_o) begin
         overrun_seen = 1'b1;
      end
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   task automatic compare_line(input logic [rx_pkg::LINE_W-1:0] got,
                               input logic [rx_pkg::LINE_W-1:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge clk_i);
      set_stb_i  <= 1'b0;
   endtask

   task automatic send_command(input logic now, input int num, input logic [63:0] t);
      write_setting(rx_pkg::SR_CMD, {now, 3'b000, 28'(num)});
      write_setting(rx_pkg::SR_TIME_HI, t[63:32]);
      write_setting(rx_pkg::SR_TIME_LO, t[31:0]);
   endtask

   task automatic get_line(output logic [rx_pkg::LINE_W-1:0] l);
      while (lines.size() == 0) begin
         @(posedge clk_i);
      end
      l = lines.pop_front();
   endtask

   // reads routing line, header, sid and time, then the payload into payload_q
   task automatic read_packet(input logic [7:0] port, input logic [31:0] sid,
                              output logic is_err, output logic [15:0] size);
      logic [rx_pkg::LINE_W-1:0] l;
      logic [15:0]               exp_size;
      get_line(l);
      size = l[15:0];
      compare_line(l, {4'b0001, port, 8'd0, size}, "routing line");
      get_line(l);
      is_err   = (l[31:28] == rx_pkg::PKT_ERROR);
      exp_size = is_err ? 16'd5 : size;
      compare_line(l, {4'b0000, is_err ? rx_pkg::PKT_ERROR : rx_pkg::PKT_DATA, 8'd0,
                       pkt_count, exp_size}, "header line");
      if (is_err) begin
         compare_line({20'd0, size}, 36'(rx_pkg::HDR_WORDS + 1), "error packet size");
      end
      pkt_count = pkt_count + 4'd1;
      get_line(l);
      compare_line(l, {4'b0000, sid}, "sid line");
      get_line(thi_line);
      get_line(tlo_line);
      payload_q.delete();
      for (int i = rx_pkg::HDR_WORDS; i < size; i++) begin
         get_line(l);
         compare_flag(l[rx_pkg::SOF_BIT], 1'b0, "payload SOF");
         compare_flag(l[rx_pkg::EOF_BIT], i == size - 1, "payload EOF");
         compare_flag(l[35] | l[34], 1'b0, "unused line bits");
         payload_q.push_back(l[31:0]);
      end
   endtask

   // payload must be consecutive strobed samples, stamped with the first one's time
   task automatic check_payload(input logic allow_pad, output int real_n);
      logic [31:0] first;
      logic [63:0] t;
      logic        padding;
      first   = payload_q[0];
      padding = 1'b0;
      real_n  = 0;
      if (!sample_time.exists(first)) begin
         $display("mismatch at %0t: payload word %h was never strobed into the DUT",
                  $time, first);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
      if (have_next) begin
         compare_line({4'b0, first}, {4'b0, next_sample}, "first sample of packet");
      end
      t = sample_time[first];
      compare_line(thi_line, {4'b0, t[63:32]}, "time hi line");
      compare_line(tlo_line, {4'b0, t[31:0]}, "time lo line");
      for (int i = 0; i < payload_q.size(); i++) begin
         if (allow_pad && i > 0 && payload_q[i] == 32'd0) begin
            padding = 1'b1;
         end
         if (padding) begin
            compare_line({4'b0, payload_q[i]}, '0, "padding word");
         end else begin
            compare_line({4'b0, payload_q[i]}, {4'b0, first + 32'(i)}, "payload word");
            real_n++;
         end
      end
      next_sample = first + 32'(real_n);
      have_next   = 1'b1;
   endtask

   task automatic expect_data(input int n);
      logic        is_err;
      logic [15:0] size;
      int          real_n;
      read_packet(8'h21, 32'hcafe0001, is_err, size);
      compare_flag(is_err, 1'b0, "data packet type");
      compare_line({20'd0, size}, 36'(rx_pkg::HDR_WORDS + n), "data packet size");
      check_payload(1'b0, real_n);
   endtask

   task automatic expect_error(input logic [7:0] code);
      logic        is_err;
      logic [15:0] size;
      read_packet(8'h21, 32'hcafe0001, is_err, size);
      compare_flag(is_err, 1'b1, "error packet type");
      compare_line({4'b0, payload_q[0]}, {28'd0, code}, "error code");
   endtask

   task automatic test_immediate();
      write_setting(rx_pkg::SR_SPP, 32'd4);
      send_command(1'b1, 10, 64'd0);
      have_next = 1'b0;
      expect_data(4);
      expect_data(4);
      expect_data(2);
   endtask

   task automatic test_timed();
      logic [63:0] t;
      t = vita_time_i + 64'd200;
      write_setting(rx_pkg::SR_SPP, 32'd8);
      send_command(1'b0, 6, t);
      have_next = 1'b0;
      while (vita_time_i < t - 64'd4) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      compare_flag(run_o, 1'b0, "run before start time");
      while (vita_time_i < t + 64'd4) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      compare_flag(run_o, 1'b1, "run during burst");
      expect_data(6);
      compare_flag(sample_time[payload_q[0]] >= t, 1'b1, "start at or after time");
      compare_flag(sample_time[payload_q[0] - 32'd1] < t, 1'b1, "start at first strobe");
      @(negedge clk_i);
      compare_flag(run_o, 1'b0, "run after burst");
   endtask

   task automatic test_late();
      // a pending timed command keeps the late one and the one behind it queued
      send_command(1'b0, 2, vita_time_i + 64'd300);
      send_command(1'b0, 4, 64'd5);
      send_command(1'b1, 4, 64'd0);
      have_next = 1'b0;
      expect_data(2);
      expect_error(rx_pkg::ERR_LATE);
      repeat (200) @(posedge clk_i);
      compare_flag(lines.size() == 0, 1'b1, "no packet after late error");
      compare_flag(run_o, 1'b0, "run after late error");
   endtask

   task automatic test_overrun();
      logic        is_err;
      logic [15:0] size;
      int          real_n, total;
      total        = 0;
      is_err       = 1'b0;
      overrun_seen = 1'b0;
      rdy_mode     = 1;
      write_setting(rx_pkg::SR_SPP, 32'd4);
      send_command(1'b1, 100, 64'd0);
      while (!overrun_seen) begin
         @(posedge clk_i);
      end
      rdy_mode  = 0;
      have_next = 1'b0;
      for (int k = 0; k < 30 && !is_err; k++) begin
         read_packet(8'h21, 32'hcafe0001, is_err, size);
         if (!is_err) begin
            compare_line({20'd0, size}, 36'd8, "data packet size before overrun");
            check_payload(1'b1, real_n);
            total += real_n;
         end
      end
      compare_flag(is_err, 1'b1, "overrun error packet arrives");
      compare_flag(total > 0, 1'b1, "buffered samples delivered");
      compare_line({4'b0, payload_q[0]}, {28'd0, rx_pkg::ERR_OVERRUN}, "overrun code");
   endtask

   task automatic test_random_ready();
      rdy_mode = 2;
      write_setting(rx_pkg::SR_SPP, 32'd5);
      send_command(1'b1, 12, 64'd0);
      have_next = 1'b0;
      expect_data(5);
      expect_data(5);
      expect_data(2);
      rdy_mode = 0;
   endtask

   task automatic test_clear();
      repeat (50) @(posedge clk_i);
      write_setting(rx_pkg::SR_CLEAR, 32'd0);
      pkt_count = 4'd0;
      write_setting(rx_pkg::SR_SPP, 32'd4);
      send_command(1'b1, 3, 64'd0);
      have_next = 1'b0;
      expect_data(3);
   endtask

   initial begin
      void'($urandom(25));
      repeat (10) @(posedge clk_i);
      rst_i <= 1'b0;
      @(posedge clk_i);
      write_setting(rx_pkg::SR_SID, 32'hcafe0001);
      write_setting(rx_pkg::SR_PORT, 32'h21);
      test_immediate();
      test_timed();
      test_late();
      test_overrun();
      test_random_ready();
      test_clear();
      repeat (20) @(posedge clk_i);
      if (lines.size() == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("unexpected lines left on the output stream");
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end
endmodule

// ==== vita_rx_chain_assertions.sv ====
/*
 * output stream and reset checks for the vita rx chain
 */
`timescale 1ns/1ps

module vita_rx_chain_assertions (
   input logic                      clk_i,
   input logic                      rst_i,
   input logic [rx_pkg::LINE_W-1:0] rx_data_o,
   input logic                      rx_src_rdy_o,
   input logic                      rx_dst_rdy_i,
   input logic                      overrun_o,
   input logic                      run_o
);
   // a stalled line stays on the bus until it is taken
   stall_holds_line: assert property (@(posedge clk_i) disable iff (rst_i)
      rx_src_rdy_o && !rx_dst_rdy_i |=> rx_src_rdy_o && $stable(rx_data_o))
      else $error("output line changed under back-pressure");

   overrun_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      overrun_o |=> !overrun_o)
      else $error("overrun longer than one cycle");

   quiet_after_reset: assert property (@(posedge clk_i)
      rst_i |=> !run_o && !overrun_o && !rx_src_rdy_o)
      else $error("outputs active after reset");
endmodule

bind vita_rx_chain vita_rx_chain_assertions assertions (
   .clk_i(clk_i), .rst_i(rst_i), .rx_data_o(rx_data_o), .rx_src_rdy_o(rx_src_rdy_o),
   .rx_dst_rdy_i(rx_dst_rdy_i), .overrun_o(overrun_o), .run_o(run_o)
);

// ==== vita_rx_chain.sv ====
/*
 * vita rx chain
 * timed sample capture, buffering, framing and routing of one receive channel
 */
`timescale 1ns/1ps

module vita_rx_chain (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     set_stb_i,
   input  logic [7:0]               set_addr_i,
   input  logic [31:0]              set_data_i,
   input  logic [63:0]              vita_time_i,
   input  logic [31:0]              sample_i,
   input  logic                     strobe_i,
   output logic [rx_pkg::LINE_W-1:0] rx_data_o,
   output logic                     rx_src_rdy_o,
   input  logic                     rx_dst_rdy_i,
   output logic                     overrun_o,
   output logic                     run_o
);
   logic        clear;
   logic [31:0] sid;
   logic [15:0] spp;
   logic [7:0]  port_sel;
   logic        cmd_push;
   logic [27:0] cmd_num;
   logic        cmd_now;
   logic [63:0] cmd_time;

   logic [rx_pkg::LINE_W-1:0] frm_data;
   logic                      frm_src_rdy, frm_dst_rdy;

   // control to FIFO, then FIFO to framer
   rx_sample_if ctrl_if ();
   rx_sample_if fifo_if ();

   rx_settings settings (
      .clk_i(clk_i), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .clear_o(clear), .sid_o(sid), .spp_o(spp), .port_sel_o(port_sel),
      .cmd_push_o(cmd_push), .cmd_num_o(cmd_num), .cmd_now_o(cmd_now),
      .cmd_time_o(cmd_time)
   );

   vita_rx_control control (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(clear),
      .cmd_push_i(cmd_push), .cmd_num_i(cmd_num), .cmd_now_i(cmd_now),
      .cmd_time_i(cmd_time), .spp_i(spp), .vita_time_i(vita_time_i),
      .sample_i(sample_i), .strobe_i(strobe_i), .out(ctrl_if.src),
      .run_o(run_o), .overrun_o(overrun_o)
   );

   rx_sample_fifo sample_fifo (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(clear),
      .in(ctrl_if.dst), .out(fifo_if.src)
   );

   vita_rx_framer framer (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(clear), .sid_i(sid),
      .in(fifo_if.dst),
      .data_o(frm_data), .src_rdy_o(frm_src_rdy), .dst_rdy_i(frm_dst_rdy)
   );

   add_routing_header routing_header (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(clear), .port_sel_i(port_sel),
      .data_i(frm_data), .src_rdy_i(frm_src_rdy), .dst_rdy_o(frm_dst_rdy),
      .data_o(rx_data_o), .src_rdy_o(rx_src_rdy_o), .dst_rdy_i(rx_dst_rdy_i)
   );
endmodule

// ==== add_routing_header.sv ====
/*
 * routing header
 * puts a line with the destination port and packet size in front of each packet
 */
`timescale 1ns/1ps

module add_routing_header (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     clear_i,
   input  logic [7:0]               port_sel_i,
   input  logic [rx_pkg::LINE_W-1:0] data_i,
   input  logic                     src_rdy_i,
   output logic                     dst_rdy_o,
   output logic [rx_pkg::LINE_W-1:0] data_o,
   output logic                     src_rdy_o,
   input  logic                     dst_rdy_i
);
   // set once the routing line of the current packet is out
   logic sent;
   logic route;

   assign route = src_rdy_i && data_i[rx_pkg::SOF_BIT] && !sent;

   always_comb begin
      data_o = data_i;
      data_o[rx_pkg::SOF_BIT] = 1'b0;
      src_rdy_o = src_rdy_i;
      dst_rdy_o = dst_rdy_i;
      if (route) begin
         // the header line is held back while the routing line goes out
         data_o                  = '0;
         data_o[31:24]           = port_sel_i;
         data_o[15:0]            = data_i[15:0];
         data_o[rx_pkg::SOF_BIT] = 1'b1;
         src_rdy_o               = 1'b1;
         dst_rdy_o               = 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         sent <= 1'b0;
      end else if (route && dst_rdy_i) begin
         sent <= 1'b1;
      end else if (src_rdy_i && dst_rdy_i && data_i[rx_pkg::SOF_BIT]) begin
         sent <= 1'b0;
      end
   end
endmodule

// ==== vita_rx_framer.sv ====
/*
 * vita rx framer
 * turns sample items into data packets and error items into error packets
 */
`timescale 1ns/1ps

module vita_rx_framer (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     clear_i,
   input  logic [31:0]              sid_i,
   rx_sample_if.dst                 in,
   output logic [rx_pkg::LINE_W-1:0] data_o,
   output logic                     src_rdy_o,
   input  logic                     dst_rdy_i
);
   typedef enum logic [1:0] {F_IDLE, F_HDR, F_PAY} fstate_t;

   fstate_t     state;
   logic [1:0]  idx;
   logic [15:0] rem, size_r;
   logic [63:0] time_r;
   logic [3:0]  pkt_cnt;
   logic        is_err;
   logic        start, pad, sof, eof;
   logic [31:0] word;

   assign start = in.valid && (in.sop || in.err);

   // an error arriving in the middle of a data packet is held back while the
   // packet is filled up with zeros to its announced size
   assign pad = (state == F_PAY) && !is_err && in.valid && in.err;

   assign in.ready = ((state == F_IDLE) && !start) ||
                     ((state == F_PAY) && dst_rdy_i && !pad);

   always_comb begin
      word      = 32'd0;
      sof       = 1'b0;
      eof       = 1'b0;
      src_rdy_o = 1'b0;
      case (state)
         F_HDR: begin
            src_rdy_o = 1'b1;
            case (idx)
               2'd0: begin
                  sof  = 1'b1;
                  word = {is_err ? rx_pkg::PKT_ERROR : rx_pkg::PKT_DATA, 8'd0, pkt_cnt, size_r};
               end
               2'd1: word = sid_i;
               2'd2: word = time_r[63:32];
               default: word = time_r[31:0];
            endcase
         end
         F_PAY: begin
            src_rdy_o = in.valid;
            word      = pad ? 32'd0 : in.data;
            eof       = is_err || (pad ? (rem == 16'd1) : in.eop);
         end
         default: ;
      endcase
      data_o                  = '0;
      data_o[31:0]            = word;
      data_o[rx_pkg::SOF_BIT] = sof;
      data_o[rx_pkg::EOF_BIT] = eof;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         state   <= F_IDLE;
         idx     <= '0;
         pkt_cnt <= '0;
      end else begin
         case (state)
            F_IDLE: begin
               if (start) begin
                  is_err <= in.err;
                  time_r <= in.vtime;
                  rem    <= in.pkt_len;
                  size_r <= in.err ? 16'(rx_pkg::HDR_WORDS + 1)
                                   : 16'(rx_pkg::HDR_WORDS) + in.pkt_len;
                  idx    <= '0;
                  state  <= F_HDR;
               end
            end
            F_HDR: begin
               if (dst_rdy_i) begin
                  idx <= idx + 2'd1;
                  if (idx == 2'd0) begin
                     pkt_cnt <= pkt_cnt + 4'd1;
                  end
                  if (idx == 2'd3) begin
                     state <= F_PAY;
                  end
               end
            end
            F_PAY: begin
               if (src_rdy_o && dst_rdy_i) begin
                  rem <= rem - 16'd1;
                  if (eof) begin
                     state <= F_IDLE;
                  end
               end
            end
            default: state <= F_IDLE;
         endcase
      end
   end
endmodule

// ==== rx_sample_fifo.sv ====
/*
 * sample FIFO
 * 16-entry synchronous FIFO for sample items with valid/ready on both sides
 */
`timescale 1ns/1ps

module rx_sample_fifo (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     clear_i,
   rx_sample_if.dst in,
   rx_sample_if.src out
);
   logic [rx_pkg::ITEM_W-1:0]  mem [1 << rx_pkg::FIFO_AW];
   logic [rx_pkg::FIFO_AW-1:0] wr_ptr, rd_ptr;
   logic [rx_pkg::FIFO_AW:0]   count;
   logic                       wr_en, rd_en;

   // the top count bit is only set when all entries are in use
   assign in.ready  = !count[rx_pkg::FIFO_AW];
   assign out.valid = (count != '0);
   assign wr_en     = in.valid && in.ready;
   assign rd_en     = out.valid && out.ready;

   assign {out.err, out.sop, out.eop, out.pkt_len, out.vtime, out.data} = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr] <= {in.err, in.sop, in.eop, in.pkt_len, in.vtime, in.data};
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (wr_en && !rd_en) begin
            count <= count + 1'b1;
         end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
         end
      end
   end
endmodule

// ==== vita_rx_control.sv ====
/*
 * vita rx control
 * queues stream commands, starts bursts on time, tags samples and raises
 * late and overrun errors
 */
`timescale 1ns/1ps

module vita_rx_control (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        clear_i,
   input  logic        cmd_push_i,
   input  logic [27:0] cmd_num_i,
   input  logic        cmd_now_i,
   input  logic [63:0] cmd_time_i,
   input  logic [15:0] spp_i,
   input  logic [63:0] vita_time_i,
   input  logic [31:0] sample_i,
   input  logic        strobe_i,
   rx_sample_if.src    out,
   output logic        run_o,
   output logic        overrun_o
);
   typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RUN, S_ERR} state_t;

   state_t state;

   // command queue
   logic        q_now  [rx_pkg::CMDQ_DEPTH];
   logic [27:0] q_num  [rx_pkg::CMDQ_DEPTH];
   logic [63:0] q_time [rx_pkg::CMDQ_DEPTH];
   logic [$clog2(rx_pkg::CMDQ_DEPTH)-1:0] q_wr, q_rd;
   logic [$clog2(rx_pkg::CMDQ_DEPTH):0]   q_cnt;
   logic q_has, q_push, q_pop, q_flush, late_head;

   // active command and burst counters
   logic        cur_now;
   logic [27:0] cur_num, left, left_cur;
   logic [63:0] cur_time;
   logic [15:0] pkt_left, pkt_cur, len;
   logic [7:0]  err_code;
   logic        start, take, first, overrun_ev;

   assign q_has     = (q_cnt != '0);
   assign late_head = !q_now[q_rd] && (vita_time_i > q_time[q_rd]);
   assign q_pop     = (state == S_IDLE) && q_has;

   assign start = (state == S_WAIT) && strobe_i && (cur_now || (vita_time_i >= cur_time));
   assign take  = start || ((state == S_RUN) && strobe_i);

   // a strobe that finds the FIFO full is lost
   assign overrun_ev = take && !out.ready;
   assign q_flush    = (q_pop && late_head) || overrun_ev;
   assign q_push     = cmd_push_i && (q_cnt != rx_pkg::CMDQ_DEPTH) && !q_flush;

   assign left_cur = start ? cur_num : left;
   assign pkt_cur  = start ? 16'd0 : pkt_left;
   assign first    = (pkt_cur == 16'd0);
   assign len      = (left_cur < {12'd0, spp_i}) ? left_cur[15:0] : spp_i;

   assign run_o = (state == S_RUN);

   always_ff @(posedge clk_i) begin
      if (q_push) begin
         q_now[q_wr]  <= cmd_now_i;
         q_num[q_wr]  <= cmd_num_i;
         q_time[q_wr] <= cmd_time_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         state     <= S_IDLE;
         q_wr      <= '0;
         q_rd      <= '0;
         q_cnt     <= '0;
         out.valid <= 1'b0;
         overrun_o <= 1'b0;
         left      <= '0;
         pkt_left  <= '0;
      end else begin
         overrun_o <= 1'b0;
         if (out.valid && out.ready) begin
            out.valid <= 1'b0;
         end

         if (q_flush) begin
            q_rd  <= q_wr;
            q_cnt <= '0;
         end else begin
            if (q_push) begin
               q_wr <= q_wr + 1'b1;
            end
            if (q_pop) begin
               q_rd <= q_rd + 1'b1;
            end
            if (q_push && !q_pop) begin
               q_cnt <= q_cnt + 1'b1;
            end else if (q_pop && !q_push) begin
               q_cnt <= q_cnt - 1'b1;
            end
         end

         case (state)
            S_IDLE: begin
               if (q_has && late_head) begin
                  err_code <= rx_pkg::ERR_LATE;
                  state    <= S_ERR;
               end else if (q_has && (q_num[q_rd] != 28'd0)) begin
                  cur_now  <= q_now[q_rd];
                  cur_num  <= q_num[q_rd];
                  cur_time <= q_time[q_rd];
                  state    <= S_WAIT;
               end
            end
            S_WAIT, S_RUN: begin
               if (overrun_ev) begin
                  overrun_o <= 1'b1;
                  err_code  <= rx_pkg::ERR_OVERRUN;
                  state     <= S_ERR;
               end else if (take) begin
                  out.valid   <= 1'b1;
                  out.data    <= sample_i;
                  out.vtime   <= vita_time_i;
                  out.pkt_len <= len;
                  out.err     <= 1'b0;
                  out.sop     <= first;
                  out.eop     <= first ? (len == 16'd1) : (pkt_cur == 16'd1);
                  pkt_left    <= first ? len - 16'd1 : pkt_cur - 16'd1;
                  left        <= left_cur - 28'd1;
                  state       <= (left_cur == 28'd1) ? S_IDLE : S_RUN;
               end
            end
            S_ERR: begin
               // the error item waits until the output slot is free
               if (!out.valid || out.ready) begin
                  out.valid   <= 1'b1;
                  out.data    <= {24'd0, err_code};
                  out.vtime   <= vita_time_i;
                  out.pkt_len <= 16'd0;
                  out.err     <= 1'b1;
                  out.sop     <= 1'b0;
                  out.eop     <= 1'b1;
                  pkt_left    <= '0;
                  state       <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end
endmodule

// ==== rx_settings.sv ====
/*
 * rx settings decoder
 * holds the stream configuration and assembles timed stream commands
 */
`timescale 1ns/1ps

module rx_settings (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   output logic        clear_o,
   output logic [31:0] sid_o,
   output logic [15:0] spp_o,
   output logic [7:0]  port_sel_o,
   output logic        cmd_push_o,
   output logic [27:0] cmd_num_o,
   output logic        cmd_now_o,
   output logic [63:0] cmd_time_o
);
   logic [15:0] spp_r;

   // a zero samples-per-packet setting behaves as one
   assign spp_o = (spp_r == 16'd0) ? 16'd1 : spp_r;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         clear_o    <= 1'b0;
         cmd_push_o <= 1'b0;
         sid_o      <= '0;
         spp_r      <= '0;
         port_sel_o <= '0;
         cmd_num_o  <= '0;
         cmd_now_o  <= 1'b0;
         cmd_time_o <= '0;
      end else begin
         clear_o    <= set_stb_i && (set_addr_i == rx_pkg::SR_CLEAR);
         // the low time word completes a command and pushes it on the next cycle
         cmd_push_o <= set_stb_i && (set_addr_i == rx_pkg::SR_TIME_LO);
         if (set_stb_i) begin
            case (set_addr_i)
               rx_pkg::SR_CMD: begin
                  cmd_now_o <= set_data_i[31];
                  cmd_num_o <= set_data_i[27:0];
               end
               rx_pkg::SR_TIME_HI: cmd_time_o[63:32] <= set_data_i;
               rx_pkg::SR_TIME_LO: cmd_time_o[31:0]  <= set_data_i;
               rx_pkg::SR_SID:     sid_o             <= set_data_i;
               rx_pkg::SR_SPP:     spp_r             <= set_data_i[15:0];
               rx_pkg::SR_PORT:    port_sel_o        <= set_data_i[7:0];
               default: ;
            endcase
         end
      end
   end
endmodule

// ==== rx_sample_if.sv ====
/*
 * sample item stream
 * carries tagged samples and error items with valid/ready flow control
 */
`timescale 1ns/1ps

interface rx_sample_if;
   logic [31:0] data;
   logic [63:0] vtime;
   logic [15:0] pkt_len;
   logic        sop;
   logic        eop;
   // data[7:0] holds an error code when set
   logic        err;
   logic        valid;
   logic        ready;

   modport src (
      output data, vtime, pkt_len, sop, eop, err, valid,
      input  ready
   );

   modport dst (
      input  data, vtime, pkt_len, sop, eop, err, valid,
      output ready
   );
endinterface

// ==== rx_pkg.sv ====
/*
 * rx chain package
 * settings addresses, line flags, packet codes and sizes shared by the receive chain
 */
package rx_pkg;

   // an output line holds 32 data bits and the flags
   localparam int LINE_W = 36;

   // settings bus addresses
   localparam logic [7:0] SR_CMD     = 8'd0;
   localparam logic [7:0] SR_TIME_HI = 8'd1;
   localparam logic [7:0] SR_TIME_LO = 8'd2;
   localparam logic [7:0] SR_CLEAR   = 8'd3;
   localparam logic [7:0] SR_SID     = 8'd4;
   localparam logic [7:0] SR_SPP     = 8'd5;
   localparam logic [7:0] SR_PORT    = 8'd6;

   localparam int CMDQ_DEPTH = 4;

   // the sample FIFO holds 16 items
   localparam int FIFO_AW = 4;

   // one stored sample item holds err, sop, eop, pkt_len, time and data
   localparam int ITEM_W = 3 + 16 + 64 + 32;

   // line flag positions with bits 35:34 kept at zero
   localparam int SOF_BIT = 32;
   localparam int EOF_BIT = 33;

   // packet type in header bits 31:28
   localparam logic [3:0] PKT_DATA  = 4'h1;
   localparam logic [3:0] PKT_ERROR = 4'h5;

   localparam logic [7:0] ERR_LATE    = 8'h02;
   localparam logic [7:0] ERR_OVERRUN = 8'h08;

   // header, sid, time hi and time lo come before the payload
   localparam int HDR_WORDS = 4;

endpackage
